//--- sources.f
hdl/riscv_isa_pkg.sv
hdl/core_types_pkg.sv
hdl/mem_req_if.sv
hdl/pipe_reg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/execute_unit.sv
hdl/mem_access_unit.sv
hdl/bus_arbiter.sv
hdl/unified_memory.sv
hdl/rv_core_top.sv
verif/rv_core_checker.sv
verif/tb_rv_core.sv

//--- verif/tb_rv_core.sv
module tb_rv_core;
	import riscv_isa_pkg::*;

	localparam int MEM_ADDR_BITS = 10;
	localparam int MEM_WORDS     = 2**MEM_ADDR_BITS;
	localparam int RUN_TIMEOUT   = 3000;

	logic                     i_clk;
	logic                     i_rst_n;
	logic                     i_run;
	logic                     i_load_we;
	logic [MEM_ADDR_BITS-1:0] i_load_addr;
	logic [31:0]              i_load_data;
	logic                     o_retire_valid;
	reg_idx_t                 o_retire_rd;
	logic [31:0]              o_retire_data;

	logic [31:0] prog [$];
	logic [31:0] ref_mem [MEM_WORDS];
	reg_idx_t    exp_rd [$];
	logic [31:0] exp_val [$];
	int          retired;
	int          checks;
	int          errors;
	int          bus_failures;
	integer      seed;

	rv_core_top #(
		.MEM_ADDR_BITS(MEM_ADDR_BITS),
		.RESET_PC(32'h0)
	) rv_core_top_inst (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_run(i_run),
		.i_load_we(i_load_we),
		.i_load_addr(i_load_addr),
		.i_load_data(i_load_data),
		.o_retire_valid(o_retire_valid),
		.o_retire_rd(o_retire_rd),
		.o_retire_data(o_retire_data)
	);

	bind bus_arbiter rv_core_checker arbiter_checker_inst (
		.i_clk(tb_rv_core.i_clk),
		.i_rst_n(tb_rv_core.i_rst_n),
		.i_loader_req(loader.req),
		.i_loader_gnt(loader.gnt),
		.i_data_req(data.req),
		.i_data_gnt(data.gnt),
		.i_fetch_req(fetch.req),
		.i_fetch_gnt(fetch.gnt)
	);

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	function automatic logic [31:0] r_type(funct3_t f3, funct7_t f7, reg_idx_t rd,
		reg_idx_t rs1, reg_idx_t rs2);
		return {f7, rs2, rs1, f3, rd, OP};
	endfunction

	function automatic logic [31:0] imm_op(funct3_t f3, reg_idx_t rd, reg_idx_t rs1,
		logic [11:0] imm);
		return {imm, rs1, f3, rd, OPIMM};
	endfunction

	function automatic logic [31:0] load_word(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
		return {imm, rs1, F3_LW_SW, rd, LOAD};
	endfunction

	function automatic logic [31:0] store_word(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, F3_LW_SW, imm[4:0], STORE};
	endfunction

	function automatic logic [31:0] branch_to(funct3_t f3, reg_idx_t rs1, reg_idx_t rs2,
		logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
	endfunction

	function automatic logic [11:0] random_imm();
		return 12'($random(seed));
	endfunction

	function automatic logic [31:0] alu_model(funct3_t f3, logic sub, logic [31:0] a,
		logic [31:0] b);
		case (f3)
			F3_ADDSUB: return sub ? a - b : a + b;
			F3_SLT:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			F3_SLTU:   return (a < b) ? 32'd1 : 32'd0;
			F3_XOR:    return a ^ b;
			F3_OR:     return a | b;
			F3_AND:    return a & b;
			default:   return '0;
		endcase
	endfunction

	// architectural run of prog, fills the expected retire queues
	function automatic void compute_expected();
		logic [31:0] regs [32];
		logic [31:0] pc;
		logic [31:0] next_pc;
		logic [31:0] insn;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] addr;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] result;
		logic [6:0]  opc;
		funct3_t     f3;
		reg_idx_t    rd;
		logic        writes;
		logic        halted;
		int          steps;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i] = (i < prog.size()) ? prog[i] : '0;
		end
		exp_rd.delete();
		exp_val.delete();
		pc     = '0;
		halted = 1'b0;
		steps  = 0;
		while (!halted && steps < 10000) begin
			insn    = ref_mem[pc[MEM_ADDR_BITS+1:2]];
			opc     = insn[6:0];
			f3      = insn[14:12];
			rd      = insn[11:7];
			a       = regs[insn[19:15]];
			b       = regs[insn[24:20]];
			imm_i   = {{20{insn[31]}}, insn[31:20]};
			imm_s   = {{20{insn[31]}}, insn[31:25], insn[11:7]};
			imm_b   = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
			next_pc = pc + 32'd4;
			writes  = 1'b0;
			result  = '0;
			case (opc)
				OP: begin
					result = alu_model(f3, insn[30], a, b);
					writes = 1'b1;
				end
				OPIMM: begin
					result = alu_model(f3, 1'b0, a, imm_i);
					writes = 1'b1;
				end
				LOAD: begin
					addr   = a + imm_i;
					result = ref_mem[addr[MEM_ADDR_BITS+1:2]];
					writes = 1'b1;
				end
				STORE: begin
					addr = a + imm_s;
					ref_mem[addr[MEM_ADDR_BITS+1:2]] = b;
				end
				BRANCH: begin
					if ((f3 == F3_BEQ) ? (a == b) : (a != b)) begin
						next_pc = pc + imm_b;
						// branch to itself ends the program
						halted  = (imm_b == '0);
					end
				end
				default: halted = 1'b1;
			endcase
			if (writes && rd != '0) begin
				regs[rd] = result;
				exp_rd.push_back(rd);
				exp_val.push_back(result);
			end
			pc = next_pc;
			steps++;
		end
	endfunction

	task automatic reg_reg_program();
		prog.delete();
		prog.push_back(imm_op(F3_ADDSUB, 5'd1, 5'd0, random_imm()));
		prog.push_back(imm_op(F3_ADDSUB, 5'd2, 5'd0, random_imm()));
		prog.push_back(imm_op(F3_ADDSUB, 5'd3, 5'd0, 12'(-5)));
		prog.push_back(imm_op(F3_ADDSUB, 5'd4, 5'd0, 12'd3));
		prog.push_back(imm_op(F3_ADDSUB, 5'd8, 5'd0, 12'd1000));
		prog.push_back(r_type(F3_ADDSUB, F7_BASE, 5'd5, 5'd1, 5'd2));
		prog.push_back(r_type(F3_ADDSUB, F7_SUB, 5'd6, 5'd3, 5'd4));
		prog.push_back(r_type(F3_ADDSUB, F7_SUB, 5'd7, 5'd1, 5'd2));
		prog.push_back(r_type(F3_ADDSUB, F7_SUB, 5'd9, 5'd4, 5'd8));
		prog.push_back(r_type(F3_AND, F7_BASE, 5'd10, 5'd1, 5'd2));
		prog.push_back(r_type(F3_OR, F7_BASE, 5'd11, 5'd1, 5'd2));
		prog.push_back(r_type(F3_XOR, F7_BASE, 5'd12, 5'd1, 5'd2));
		// -5 against 3, signed and unsigned disagree
		prog.push_back(r_type(F3_SLT, F7_BASE, 5'd13, 5'd3, 5'd4));
		prog.push_back(r_type(F3_SLTU, F7_BASE, 5'd14, 5'd3, 5'd4));
		prog.push_back(r_type(F3_SLT, F7_BASE, 5'd15, 5'd4, 5'd3));
		prog.push_back(r_type(F3_SLTU, F7_BASE, 5'd16, 5'd4, 5'd3));
		prog.push_back(r_type(F3_SLT, F7_BASE, 5'd17, 5'd1, 5'd2));
		prog.push_back(r_type(F3_SLTU, F7_BASE, 5'd18, 5'd1, 5'd2));
		prog.push_back(branch_to(F3_BEQ, 5'd0, 5'd0, 13'd0));
	endtask

	task automatic immediate_program();
		prog.delete();
		prog.push_back(imm_op(F3_ADDSUB, 5'd1, 5'd0, random_imm()));
		prog.push_back(imm_op(F3_ADDSUB, 5'd2, 5'd1, 12'(-100)));
		prog.push_back(imm_op(F3_AND, 5'd3, 5'd1, 12'(-16)));
		prog.push_back(imm_op(F3_OR, 5'd4, 5'd0, 12'h800));
		prog.push_back(imm_op(F3_XOR, 5'd5, 5'd1, 12'(-1)));
		prog.push_back(imm_op(F3_SLT, 5'd6, 5'd1, 12'(-1)));
		prog.push_back(imm_op(F3_SLT, 5'd7, 5'd4, 12'd5));
		prog.push_back(imm_op(F3_SLT, 5'd8, 5'd4, 12'h800));
		// write to x0, then read it back
		prog.push_back(imm_op(F3_ADDSUB, 5'd0, 5'd1, 12'd7));
		prog.push_back(r_type(F3_ADDSUB, F7_BASE, 5'd9, 5'd0, 5'd1));
		prog.push_back(imm_op(F3_OR, 5'd10, 5'd0, 12'd0));
		prog.push_back(imm_op(F3_XOR, 5'd11, 5'd0, 12'(-7)));
		prog.push_back(branch_to(F3_BEQ, 5'd0, 5'd0, 13'd0));
	endtask

	task automatic dependency_program();
		prog.delete();
		prog.push_back(imm_op(F3_ADDSUB, 5'd1, 5'd0, random_imm()));
		prog.push_back(imm_op(F3_ADDSUB, 5'd1, 5'd1, random_imm()));
		prog.push_back(r_type(F3_ADDSUB, F7_BASE, 5'd2, 5'd1, 5'd1));
		prog.push_back(r_type(F3_ADDSUB, F7_SUB, 5'd3, 5'd2, 5'd1));
		prog.push_back(r_type(F3_XOR, F7_BASE, 5'd4, 5'd3, 5'd2));
		prog.push_back(r_type(F3_ADDSUB, F7_BASE, 5'd4, 5'd4, 5'd4));
		prog.push_back(r_type(F3_AND, F7_BASE, 5'd5, 5'd4, 5'd3));
		prog.push_back(r_type(F3_OR, F7_BASE, 5'd6, 5'd5, 5'd1));
		prog.push_back(r_type(F3_SLT, F7_BASE, 5'd7, 5'd6, 5'd4));
		prog.push_back(r_type(F3_SLTU, F7_BASE, 5'd8, 5'd7, 5'd6));
		prog.push_back(imm_op(F3_ADDSUB, 5'd9, 5'd8, random_imm()));
		for (int i = 0; i < 6; i++) begin
			prog.push_back(r_type(F3_ADDSUB, F7_BASE, 5'(10 + i), 5'(9 + i), 5'd1));
		end
		prog.push_back(branch_to(F3_BEQ, 5'd0, 5'd0, 13'd0));
	endtask

	task automatic memory_program();
		prog.delete();
		prog.push_back(imm_op(F3_ADDSUB, 5'd1, 5'd0, 12'h400));
		prog.push_back(imm_op(F3_ADDSUB, 5'd2, 5'd0, random_imm()));
		prog.push_back(imm_op(F3_ADDSUB, 5'd3, 5'd0, random_imm()));
		prog.push_back(store_word(5'd2, 5'd1, 12'd0));
		prog.push_back(load_word(5'd4, 5'd1, 12'd0));
		prog.push_back(store_word(5'd3, 5'd1, 12'd8));
		prog.push_back(store_word(5'd4, 5'd1, 12'(-4)));
		prog.push_back(load_word(5'd5, 5'd1, 12'd8));
		prog.push_back(load_word(5'd6, 5'd1, 12'(-4)));
		prog.push_back(r_type(F3_ADDSUB, F7_BASE, 5'd7, 5'd5, 5'd6));
		prog.push_back(store_word(5'd7, 5'd1, 12'd12));
		// overwrite the first word
		prog.push_back(store_word(5'd3, 5'd1, 12'd0));
		prog.push_back(load_word(5'd8, 5'd1, 12'd0));
		prog.push_back(load_word(5'd9, 5'd1, 12'd12));
		prog.push_back(load_word(5'd10, 5'd1, 12'd8));
		prog.push_back(branch_to(F3_BEQ, 5'd0, 5'd0, 13'd0));
	endtask

	task automatic branch_program();
		prog.delete();
		prog.push_back(imm_op(F3_ADDSUB, 5'd1, 5'd0, 12'd5));
		prog.push_back(imm_op(F3_ADDSUB, 5'd2, 5'd0, 12'd5));
		prog.push_back(imm_op(F3_ADDSUB, 5'd3, 5'd0, 12'd7));
		prog.push_back(branch_to(F3_BEQ, 5'd1, 5'd2, 13'd8));
		prog.push_back(imm_op(F3_ADDSUB, 5'd10, 5'd0, 12'd1));
		prog.push_back(imm_op(F3_ADDSUB, 5'd11, 5'd0, 12'd2));
		prog.push_back(branch_to(F3_BNE, 5'd1, 5'd3, 13'd8));
		prog.push_back(imm_op(F3_ADDSUB, 5'd12, 5'd0, 12'd3));
		prog.push_back(imm_op(F3_ADDSUB, 5'd13, 5'd0, 12'd4));
		// not taken, both kinds
		prog.push_back(branch_to(F3_BEQ, 5'd1, 5'd3, 13'd8));
		prog.push_back(imm_op(F3_ADDSUB, 5'd14, 5'd0, 12'd5));
		prog.push_back(branch_to(F3_BNE, 5'd1, 5'd2, 13'd8));
		prog.push_back(imm_op(F3_ADDSUB, 5'd15, 5'd0, 12'd6));
		// count down loop
		prog.push_back(imm_op(F3_ADDSUB, 5'd16, 5'd0, 12'd3));
		prog.push_back(imm_op(F3_ADDSUB, 5'd16, 5'd16, 12'(-1)));
		prog.push_back(branch_to(F3_BNE, 5'd16, 5'd0, 13'(-4)));
		prog.push_back(branch_to(F3_BEQ, 5'd2, 5'd1, 13'd8));
		prog.push_back(imm_op(F3_ADDSUB, 5'd17, 5'd0, 12'd9));
		prog.push_back(branch_to(F3_BEQ, 5'd0, 5'd0, 13'd0));
	endtask

	task automatic reset_core();
		@(posedge i_clk);
		#1;
		i_rst_n   = 1'b0;
		i_run     = 1'b0;
		i_load_we = 1'b0;
		repeat (3) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;
	endtask

	task automatic load_program();
		foreach (prog[i]) begin
			@(posedge i_clk);
			#1;
			i_load_we   = 1'b1;
			i_load_addr = MEM_ADDR_BITS'(i);
			i_load_data = prog[i];
		end
		@(posedge i_clk);
		#1;
		i_load_we = 1'b0;
	endtask

	task automatic start_program();
		reset_core();
		load_program();
		compute_expected();
		@(posedge i_clk);
		#1;
		i_run = 1'b1;
	endtask

	task automatic run_program(input string name);
		int base_count;
		int total;
		int cycles;
		start_program();
		base_count = retired;
		total      = exp_rd.size();
		cycles     = 0;
		while (exp_rd.size() > 0 && cycles < RUN_TIMEOUT) begin
			@(posedge i_clk);
			cycles++;
		end
		assert (exp_rd.size() == 0) else begin
			errors++;
			$display("%s: timed out with %0d retires still missing", name, exp_rd.size());
		end
		// quiet period catches late or extra retires
		repeat (20) @(posedge i_clk);
		assert (retired - base_count == total) else begin
			errors++;
			$display("ERROR at %0t: %s retire count expected %0d got %0d", $time, name,
				total, retired - base_count);
		end
	endtask

	task automatic reset_mid_run();
		int base_count;
		int cycles;
		start_program();
		base_count = retired;
		cycles     = 0;
		while (retired - base_count < 4 && cycles < RUN_TIMEOUT) begin
			@(posedge i_clk);
			cycles++;
		end
		assert (retired - base_count >= 4) else begin
			errors++;
			$display("mid-run reset: the core never reached four retires");
		end
		@(posedge i_clk);
		#1;
		i_rst_n = 1'b0;
		i_run   = 1'b0;
		@(posedge i_clk);
		repeat (3) begin
			@(negedge i_clk);
			assert (!o_retire_valid) else begin
				errors++;
				$display("ERROR at %0t: o_retire_valid expected 0 got %b", $time,
					o_retire_valid);
			end
		end
	endtask

	// retire compare, sampled away from the active edge
	always @(negedge i_clk) begin
		if (i_rst_n && o_retire_valid) begin
			retired++;
			assert (exp_rd.size() > 0) else begin
				errors++;
				$display("retire of x%0d at %0t was not expected by the model", o_retire_rd,
					$time);
			end
			if (exp_rd.size() > 0) begin
				checks++;
				assert (o_retire_rd == exp_rd[0]) else begin
					errors++;
					$display("ERROR at %0t: o_retire_rd expected %0d got %0d", $time,
						exp_rd[0], o_retire_rd);
				end
				assert (o_retire_data == exp_val[0]) else begin
					errors++;
					$display("ERROR at %0t: o_retire_data expected %h got %h", $time,
						exp_val[0], o_retire_data);
				end
				void'(exp_rd.pop_front());
				void'(exp_val.pop_front());
			end
		end
	end

	initial begin
		seed        = 91827;
		retired     = 0;
		checks      = 0;
		errors      = 0;
		i_rst_n     = 1'b0;
		i_run       = 1'b0;
		i_load_we   = 1'b0;
		i_load_addr = '0;
		i_load_data = '0;
		reg_reg_program();
		run_program("register ops");
		immediate_program();
		run_program("immediate ops");
		dependency_program();
		run_program("dependent chain");
		memory_program();
		run_program("load and store");
		branch_program();
		run_program("branches");
		reg_reg_program();
		reset_mid_run();
		run_program("rerun after reset");
		bus_failures = rv_core_top_inst.bus_arbiter_inst.arbiter_checker_inst.failures;
		$display("retire checks: %0d, errors: %0d, bus assertion failures: %0d", checks,
			errors, bus_failures);
		if (errors == 0 && bus_failures == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- verif/rv_core_checker.sv
module rv_core_checker (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_loader_req,
	input logic i_loader_gnt,
	input logic i_data_req,
	input logic i_data_gnt,
	input logic i_fetch_req,
	input logic i_fetch_gnt
);

	int failures = 0;

	property single_grant;
		@(posedge i_clk) disable iff (!i_rst_n)
			$onehot0({i_loader_gnt, i_data_gnt, i_fetch_gnt});
	endproperty

	property grant_needs_request;
		@(posedge i_clk) disable iff (!i_rst_n)
			(!i_loader_gnt || i_loader_req) && (!i_data_gnt || i_data_req) &&
			(!i_fetch_gnt || i_fetch_req);
	endproperty

	// loader first, then data, then fetch
	property data_beats_fetch;
		@(posedge i_clk) disable iff (!i_rst_n)
			(i_data_req && !i_loader_req) |-> i_data_gnt;
	endproperty

	single_grant_a: assert property (single_grant)
		else begin
			failures++;
			$error("more than one requester holds a grant on the memory bus");
		end
	grant_needs_request_a: assert property (grant_needs_request)
		else begin
			failures++;
			$error("a requester was granted the memory bus without asking for it");
		end
	data_beats_fetch_a: assert property (data_beats_fetch)
		else begin
			failures++;
			$error("the data requester was refused while the loader was idle");
		end

endmodule

//--- hdl/rv_core_top.sv
module rv_core_top #(
	parameter int                    MEM_ADDR_BITS = 10,
	parameter core_types_pkg::word_t RESET_PC      = '0
) (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_run,
	input  logic                     i_load_we,
	input  logic [MEM_ADDR_BITS-1:0] i_load_addr,
	input  core_types_pkg::word_t    i_load_data,
	output logic                     o_retire_valid,
	output riscv_isa_pkg::reg_idx_t  o_retire_rd,
	output core_types_pkg::word_t    o_retire_data
);
	import core_types_pkg::*;

	logic    fetch_valid;
	if_id_t  fetch_data;
	logic    if_id_valid;
	if_id_t  if_id_data;
	logic    dec_stall;
	logic    dec_redirect;
	word_t   dec_target;
	logic    dec_valid;
	id_ex_t  dec_data;
	logic    id_ex_valid;
	id_ex_t  id_ex_data;
	logic    ex_valid;
	ex_mem_t ex_data;
	logic    ex_mem_valid;
	ex_mem_t ex_mem_data;
	logic    mem_valid;
	mem_wb_t mem_data;
	logic    mem_wb_valid;
	mem_wb_t mem_wb_data;
	logic    wb_en;

	mem_req_if #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) loader_bus ();
	mem_req_if #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) data_bus ();
	mem_req_if #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) fetch_bus ();
	mem_req_if #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) mem_bus ();

	// program load only while halted
	assign loader_bus.req   = !i_run && i_load_we;
	assign loader_bus.we    = i_load_we;
	assign loader_bus.addr  = i_load_addr;
	assign loader_bus.wdata = i_load_data;

	fetch_unit #(
		.MEM_ADDR_BITS(MEM_ADDR_BITS),
		.RESET_PC(RESET_PC)
	) fetch_unit_inst (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_run(i_run),
		.i_stall(dec_stall),
		.i_redirect(dec_redirect),
		.i_target(dec_target),
		.bus(fetch_bus.requester),
		.o_valid(fetch_valid),
		.o_data(fetch_data)
	);

	pipe_reg #(.PAYLOAD_T(if_id_t)) if_id_reg (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_hold(dec_stall),
		.i_squash(dec_redirect),
		.i_valid(fetch_valid),
		.i_data(fetch_data),
		.o_valid(if_id_valid),
		.o_data(if_id_data)
	);

	decode_unit decode_unit_inst (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_valid(if_id_valid),
		.i_data(if_id_data),
		.i_ex_valid(id_ex_valid),
		.i_ex_rd(id_ex_data.rd),
		.i_mem_valid(ex_mem_valid),
		.i_mem_rd(ex_mem_data.rd),
		.i_wb_en(wb_en),
		.i_wb_rd(mem_wb_data.rd),
		.i_wb_data(mem_wb_data.result),
		.o_stall(dec_stall),
		.o_redirect(dec_redirect),
		.o_target(dec_target),
		.o_valid(dec_valid),
		.o_data(dec_data)
	);

	// interlock bubble goes in here
	pipe_reg #(.PAYLOAD_T(id_ex_t)) id_ex_reg (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_hold(1'b0),
		.i_squash(dec_stall),
		.i_valid(dec_valid),
		.i_data(dec_data),
		.o_valid(id_ex_valid),
		.o_data(id_ex_data)
	);

	execute_unit execute_unit_inst (
		.i_valid(id_ex_valid),
		.i_data(id_ex_data),
		.o_valid(ex_valid),
		.o_data(ex_data)
	);

	pipe_reg #(.PAYLOAD_T(ex_mem_t)) ex_mem_reg (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_hold(1'b0),
		.i_squash(1'b0),
		.i_valid(ex_valid),
		.i_data(ex_data),
		.o_valid(ex_mem_valid),
		.o_data(ex_mem_data)
	);

	mem_access_unit #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) mem_access_unit_inst (
		.i_valid(ex_mem_valid),
		.i_data(ex_mem_data),
		.bus(data_bus.requester),
		.o_valid(mem_valid),
		.o_data(mem_data)
	);

	pipe_reg #(.PAYLOAD_T(mem_wb_t)) mem_wb_reg (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_hold(1'b0),
		.i_squash(1'b0),
		.i_valid(mem_valid),
		.i_data(mem_data),
		.o_valid(mem_wb_valid),
		.o_data(mem_wb_data)
	);

	bus_arbiter bus_arbiter_inst (
		.loader(loader_bus.arbiter),
		.data(data_bus.arbiter),
		.fetch(fetch_bus.arbiter),
		.mem(mem_bus.requester)
	);

	unified_memory #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) unified_memory_inst (
		.i_clk(i_clk),
		.port(mem_bus.arbiter)
	);

	// writeback doubles as retire
	assign wb_en          = mem_wb_valid && (mem_wb_data.rd != '0);
	assign o_retire_valid = wb_en;
	assign o_retire_rd    = mem_wb_data.rd;
	assign o_retire_data  = mem_wb_data.result;

endmodule

//--- hdl/unified_memory.sv
module unified_memory #(
	parameter int MEM_ADDR_BITS = 10
) (
	input logic        i_clk,
	mem_req_if.arbiter port
);
	import core_types_pkg::*;

	word_t mem [2**MEM_ADDR_BITS];

	// single master, never refused
	assign port.gnt   = 1'b1;
	assign port.rdata = mem[port.addr];

	always_ff @(posedge i_clk) begin
		if (port.req && port.we) begin
			mem[port.addr] <= port.wdata;
		end
	end

endmodule

//--- hdl/bus_arbiter.sv
module bus_arbiter (
	mem_req_if.arbiter   loader,
	mem_req_if.arbiter   data,
	mem_req_if.arbiter   fetch,
	mem_req_if.requester mem
);

	logic sel_loader;
	logic sel_data;
	logic sel_fetch;

	// fixed order: loader, data, fetch
	assign sel_loader = loader.req;
	assign sel_data   = data.req && !loader.req;
	assign sel_fetch  = fetch.req && !loader.req && !data.req;

	assign loader.gnt = sel_loader && mem.gnt;
	assign data.gnt   = sel_data && mem.gnt;
	assign fetch.gnt  = sel_fetch && mem.gnt;

	assign mem.req = loader.req || data.req || fetch.req;

	always_comb begin
		mem.we    = fetch.we;
		mem.addr  = fetch.addr;
		mem.wdata = fetch.wdata;
		if (sel_loader) begin
			mem.we    = loader.we;
			mem.addr  = loader.addr;
			mem.wdata = loader.wdata;
		end else if (sel_data) begin
			mem.we    = data.we;
			mem.addr  = data.addr;
			mem.wdata = data.wdata;
		end
	end

	assign loader.rdata = mem.rdata;
	assign data.rdata   = mem.rdata;
	assign fetch.rdata  = mem.rdata;

endmodule

//--- hdl/mem_access_unit.sv
module mem_access_unit #(
	parameter int MEM_ADDR_BITS = 10
) (
	input  logic                    i_valid,
	input  core_types_pkg::ex_mem_t i_data,
	mem_req_if.requester            bus,
	output logic                    o_valid,
	output core_types_pkg::mem_wb_t o_data
);

	// word address, byte offset ignored
	assign bus.req   = i_valid && (i_data.is_load || i_data.is_store);
	assign bus.we    = i_data.is_store;
	assign bus.addr  = i_data.result[MEM_ADDR_BITS+1:2];
	assign bus.wdata = i_data.store_data;

	assign o_valid = i_valid && !i_data.is_store;

	always_comb begin
		o_data.result = i_data.is_load ? bus.rdata : i_data.result;
		o_data.rd     = i_data.rd;
	end

endmodule

//--- hdl/execute_unit.sv
module execute_unit (
	input  logic                    i_valid,
	input  core_types_pkg::id_ex_t  i_data,
	output logic                    o_valid,
	output core_types_pkg::ex_mem_t o_data
);
	import core_types_pkg::*;

	word_t op_a;
	word_t op_b;
	word_t result;

	assign op_a = i_data.rs1_val;
	assign op_b = i_data.use_imm ? i_data.imm : i_data.rs2_val;

	// loads and stores come in as ALU_ADD
	always_comb begin
		case (i_data.alu_op)
			ALU_ADD:  result = op_a + op_b;
			ALU_SUB:  result = op_a - op_b;
			ALU_AND:  result = op_a & op_b;
			ALU_OR:   result = op_a | op_b;
			ALU_XOR:  result = op_a ^ op_b;
			ALU_SLT:  result = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
			ALU_SLTU: result = {{(XLEN-1){1'b0}}, (op_a < op_b)};
			default:  result = '0;
		endcase
	end

	assign o_valid = i_valid;

	always_comb begin
		o_data.result     = result;
		o_data.store_data = i_data.rs2_val;
		o_data.rd         = i_data.rd;
		o_data.is_load    = i_data.is_load;
		o_data.is_store   = i_data.is_store;
	end

endmodule

//--- hdl/decode_unit.sv
module decode_unit (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_valid,
	input  core_types_pkg::if_id_t  i_data,
	input  logic                    i_ex_valid,
	input  riscv_isa_pkg::reg_idx_t i_ex_rd,
	input  logic                    i_mem_valid,
	input  riscv_isa_pkg::reg_idx_t i_mem_rd,
	input  logic                    i_wb_en,
	input  riscv_isa_pkg::reg_idx_t i_wb_rd,
	input  core_types_pkg::word_t   i_wb_data,
	output logic                    o_stall,
	output logic                    o_redirect,
	output core_types_pkg::word_t   o_target,
	output logic                    o_valid,
	output core_types_pkg::id_ex_t  o_data
);
	import riscv_isa_pkg::*;
	import core_types_pkg::*;

	word_t    regs [32];
	opcode_t  opcode;
	funct3_t  funct3;
	funct7_t  funct7;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	word_t    rs1_val;
	word_t    rs2_val;
	word_t    imm_i;
	word_t    imm_s;
	word_t    imm_b;
	alu_op_t  alu_op;
	logic     legal;
	logic     is_branch;
	logic     use_imm;
	logic     is_load;
	logic     is_store;
	logic     uses_rs2;
	logic     hazard_rs1;
	logic     hazard_rs2;
	logic     branch_taken;

	assign opcode = opcode_t'(i_data.insn[6:0]);
	assign funct3 = i_data.insn[14:12];
	assign funct7 = i_data.insn[31:25];
	assign rs1    = i_data.insn[19:15];
	assign rs2    = i_data.insn[24:20];
	assign rd     = i_data.insn[11:7];

	assign imm_i = {{20{i_data.insn[31]}}, i_data.insn[31:20]};
	assign imm_s = {{20{i_data.insn[31]}}, i_data.insn[31:25], i_data.insn[11:7]};
	assign imm_b = {{19{i_data.insn[31]}}, i_data.insn[31], i_data.insn[7],
		i_data.insn[30:25], i_data.insn[11:8], 1'b0};

	always_ff @(posedge i_clk) begin
		if (i_rst_n && i_wb_en) begin
			regs[i_wb_rd] <= i_wb_data;
		end
	end

	// x0 forced to zero, writeback forwarded in the same cycle
	assign rs1_val = (rs1 == '0) ? '0 : (i_wb_en && i_wb_rd == rs1) ? i_wb_data : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : (i_wb_en && i_wb_rd == rs2) ? i_wb_data : regs[rs2];

	always_comb begin
		alu_op    = ALU_ADD;
		legal     = 1'b0;
		is_branch = 1'b0;
		use_imm   = 1'b0;
		is_load   = 1'b0;
		is_store  = 1'b0;
		uses_rs2  = 1'b0;
		case (opcode)
			OP: begin
				uses_rs2 = 1'b1;
				legal    = (funct7 == F7_BASE) || (funct7 == F7_SUB && funct3 == F3_ADDSUB);
				case (funct3)
					F3_ADDSUB: alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
					F3_SLT:    alu_op = ALU_SLT;
					F3_SLTU:   alu_op = ALU_SLTU;
					F3_XOR:    alu_op = ALU_XOR;
					F3_OR:     alu_op = ALU_OR;
					F3_AND:    alu_op = ALU_AND;
					default:   legal = 1'b0;
				endcase
			end
			OPIMM: begin
				use_imm = 1'b1;
				legal   = 1'b1;
				case (funct3)
					F3_ADDSUB: alu_op = ALU_ADD;
					F3_SLT:    alu_op = ALU_SLT;
					F3_XOR:    alu_op = ALU_XOR;
					F3_OR:     alu_op = ALU_OR;
					F3_AND:    alu_op = ALU_AND;
					// shifts and sltiu not kept
					default:   legal = 1'b0;
				endcase
			end
			LOAD: begin
				use_imm = 1'b1;
				is_load = 1'b1;
				legal   = (funct3 == F3_LW_SW);
			end
			STORE: begin
				use_imm  = 1'b1;
				is_store = 1'b1;
				uses_rs2 = 1'b1;
				legal    = (funct3 == F3_LW_SW);
			end
			BRANCH: begin
				uses_rs2  = 1'b1;
				is_branch = 1'b1;
				legal     = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
			end
			default: legal = 1'b0;
		endcase
	end

	// operands still in flight in execute or memory
	assign hazard_rs1 = (rs1 != '0) &&
		((i_ex_valid && i_ex_rd == rs1) || (i_mem_valid && i_mem_rd == rs1));
	assign hazard_rs2 = uses_rs2 && (rs2 != '0) &&
		((i_ex_valid && i_ex_rd == rs2) || (i_mem_valid && i_mem_rd == rs2));
	assign o_stall = i_valid && legal && (hazard_rs1 || hazard_rs2);

	assign branch_taken = (rs1_val == rs2_val) ^ (funct3 == F3_BNE);
	assign o_redirect   = i_valid && legal && is_branch && branch_taken && !o_stall;
	assign o_target     = i_data.pc + imm_b;

	assign o_valid = i_valid && legal && !is_branch;

	always_comb begin
		o_data.pc       = i_data.pc;
		o_data.rs1_val  = rs1_val;
		o_data.rs2_val  = rs2_val;
		o_data.imm      = is_store ? imm_s : imm_i;
		o_data.rd       = is_store ? '0 : rd;
		o_data.alu_op   = alu_op;
		o_data.use_imm  = use_imm;
		o_data.is_load  = is_load;
		o_data.is_store = is_store;
	end

endmodule

//--- hdl/fetch_unit.sv
module fetch_unit #(
	parameter int                    MEM_ADDR_BITS = 10,
	parameter core_types_pkg::word_t RESET_PC      = '0
) (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_run,
	input  logic                   i_stall,
	input  logic                   i_redirect,
	input  core_types_pkg::word_t  i_target,
	mem_req_if.requester           bus,
	output logic                   o_valid,
	output core_types_pkg::if_id_t o_data
);
	import core_types_pkg::*;

	word_t pc;

	// instruction reads only
	assign bus.req   = i_run;
	assign bus.we    = 1'b0;
	assign bus.addr  = pc[MEM_ADDR_BITS+1:2];
	assign bus.wdata = '0;

	// the fall-through word is dropped on a taken branch
	assign o_valid = bus.gnt && !i_redirect;
	assign o_data  = '{pc: pc, insn: bus.rdata};

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			pc <= RESET_PC;
		end else if (i_redirect) begin
			pc <= i_target;
		end else if (bus.gnt && !i_stall) begin
			pc <= pc + 32'd4;
		end
	end

endmodule

//--- hdl/pipe_reg.sv
module pipe_reg #(
	parameter type PAYLOAD_T = logic
) (
	input  logic     i_clk,
	input  logic     i_rst_n,
	input  logic     i_hold,
	input  logic     i_squash,
	input  logic     i_valid,
	input  PAYLOAD_T i_data,
	output logic     o_valid,
	output PAYLOAD_T o_data
);

	// squash wins over hold
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_valid <= 1'b0;
		end else if (i_squash) begin
			o_valid <= 1'b0;
		end else if (!i_hold) begin
			o_valid <= i_valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_hold) begin
			o_data <= i_data;
		end
	end

endmodule

//--- hdl/mem_req_if.sv
interface mem_req_if #(
	parameter int MEM_ADDR_BITS = 10
);
	import core_types_pkg::*;

	logic                     req;
	logic                     we;
	logic [MEM_ADDR_BITS-1:0] addr;
	word_t                    wdata;
	word_t                    rdata;
	logic                     gnt;

	// access happens when req and gnt are both high
	modport requester (output req, we, addr, wdata, input rdata, gnt);
	modport arbiter (input req, we, addr, wdata, output rdata, gnt);

endinterface

//--- hdl/core_types_pkg.sv
package core_types_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU
	} alu_op_t;

	typedef struct packed {
		word_t pc;
		word_t insn;
	} if_id_t;

	typedef struct packed {
		word_t                   pc;
		word_t                   rs1_val;
		word_t                   rs2_val;
		word_t                   imm;
		riscv_isa_pkg::reg_idx_t rd;
		alu_op_t                 alu_op;
		logic                    use_imm;
		logic                    is_load;
		logic                    is_store;
	} id_ex_t;

	typedef struct packed {
		word_t                   result;
		word_t                   store_data;
		riscv_isa_pkg::reg_idx_t rd;
		logic                    is_load;
		logic                    is_store;
	} ex_mem_t;

	// rd of zero means nothing to write
	typedef struct packed {
		word_t                   result;
		riscv_isa_pkg::reg_idx_t rd;
	} mem_wb_t;

endpackage

//--- hdl/riscv_isa_pkg.sv
package riscv_isa_pkg;

	// major opcodes kept in this core
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OPIMM  = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011
	} opcode_t;

	typedef logic [4:0] reg_idx_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	// funct3 for OP and OPIMM
	localparam funct3_t F3_ADDSUB = 3'b000;
	localparam funct3_t F3_SLT    = 3'b010;
	localparam funct3_t F3_SLTU   = 3'b011;
	localparam funct3_t F3_XOR    = 3'b100;
	localparam funct3_t F3_OR     = 3'b110;
	localparam funct3_t F3_AND    = 3'b111;

	// funct3 for branches and word access
	localparam funct3_t F3_BEQ    = 3'b000;
	localparam funct3_t F3_BNE    = 3'b001;
	localparam funct3_t F3_LW_SW  = 3'b010;

	localparam funct7_t F7_BASE   = 7'b0000000;
	localparam funct7_t F7_SUB    = 7'b0100000;

endpackage
